// File: verilog.f
src/memMapPkg.sv
src/busPkg.sv
src/SramMacro.sv
src/FlashController.sv
src/LocalMemoryInterface.sv
src/LocalMemorySubsystem.sv
testbench/LocalMemorySubsystemTb.sv

// File: runSim.sh
#!/bin/sh
# Verilator build and run of the local memory testbench
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module LocalMemorySubsystemTb -f verilog.f > build.log 2>&1 &&
	./obj_dir/VLocalMemorySubsystemTb > sim.log 2>&1 ||
	{ echo "Build or simulation did not complete"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log

# The log decides the result
grep -qx "Verification passed" sim.log && echo "Simulation PASSED" ||
	{ echo "Simulation FAILED"; exit 1; }

// File: testbench/LocalMemorySubsystemTb.sv
`default_nettype none

module LocalMemorySubsystemTb;

	import memMapPkg::*;
	import busPkg::*;

	localparam int sramAddressSize = 9;
	localparam int flashWaitCycles = 4;
	localparam int resetCycles = 16;
	localparam int clearCycles = 1024;
	localparam int windowWords = 64; // SRAM words in play
	localparam int sramOps = 48;
	localparam int wbOps = 48;
	localparam int collisionRounds = 16;
	localparam int flashOps = 24;
	localparam int rangeOps = 12;
	localparam int mixedCycles = 300;
	localparam int testLengths = windowWords + 2 * sramOps + 2 * wbOps + 8
		+ 4 * collisionRounds + 2 * flashOps + 1 + 4 * rangeOps + mixedCycles;
	localparam int watchdogCycles = testLengths * (flashWaitCycles + 3) + resetCycles + clearCycles;

	logic clk;
	logic rst;
	logic [addressWidth-1:0] coreAddress;
	logic [byteSelectWidth-1:0] coreByteSelect;
	logic coreWriteEnable;
	logic coreReadEnable;
	logic [dataWidth-1:0] coreDataWrite;
	logic [dataWidth-1:0] coreDataRead;
	logic coreBusy;
	logic [addressWidth-1:0] wbAddress;
	logic [byteSelectWidth-1:0] wbByteSelect;
	logic wbWriteEnable;
	logic wbReadEnable;
	logic [dataWidth-1:0] wbDataWrite;
	logic [dataWidth-1:0] wbDataRead;
	logic wbWriteBusy;

	integer seed = 32'he9d9_6944;
	int errorCount = 0;
	int testErrors = 0;
	logic [dataWidth-1:0] refSram [2 ** sramAddressSize];
	logic [dataWidth-1:0] refFlash [1024];
	logic coreReadValid;
	logic wbReadValid;
	logic [dataWidth-1:0] coreExpect;
	logic [dataWidth-1:0] wbExpect;

	function automatic logic inSram(input logic [addressWidth-1:0] address);
		return address[addressWidth-1 -: 4] == regionSram
			&& (address[19:0] >> (sramAddressSize + 2)) == 0;
	endfunction

	function automatic logic [dataWidth-1:0] mergeLanes(input logic [dataWidth-1:0] old,
			input logic [dataWidth-1:0] data, input logic [byteSelectWidth-1:0] lanes);
		logic [dataWidth-1:0] result;
		result = old;
		for (int lane = 0; lane < byteSelectWidth; lane++)
			if (lanes[lane])
				result[lane*8 +: 8] = data[lane*8 +: 8];
		return result;
	endfunction

	function automatic int randomBelow(input int limit);
		return $unsigned($random(seed)) % limit;
	endfunction

	function automatic logic [addressWidth-1:0] sramAddress(input int index);
		return {regionSram, 20'(index * 4 + randomBelow(4))}; // Any byte lane
	endfunction

	function automatic logic [addressWidth-1:0] flashAddressAt(input int index);
		return {regionFlash, 8'($random(seed)), 10'(index), 2'($random(seed))};
	endfunction

	// Request decode from the address map
	wire coreSramReq = (coreWriteEnable || coreReadEnable) && inSram(coreAddress);
	wire wbSramReq = (wbWriteEnable || wbReadEnable) && inSram(wbAddress);
	wire coreFlashReq = (coreWriteEnable || coreReadEnable)
		&& coreAddress[addressWidth-1 -: 4] == regionFlash;
	wire wbWriteReq = wbSramReq && !wbReadEnable;
	wire [sramAddressSize-1:0] coreIndex = coreAddress[2 +: sramAddressSize];
	wire [sramAddressSize-1:0] wbIndex = wbAddress[2 +: sramAddressSize];

	LocalMemorySubsystem #(
		.sramAddressSize(sramAddressSize),
		.flashWaitCycles(flashWaitCycles)
	) u_LocalMemorySubsystem (
		.clk, .rst,
		.coreAddress, .coreByteSelect, .coreWriteEnable, .coreReadEnable,
		.coreDataWrite, .coreDataRead, .coreBusy,
		.wbAddress, .wbByteSelect, .wbWriteEnable, .wbReadEnable,
		.wbDataWrite, .wbDataRead, .wbWriteBusy
	);

	// Reference SRAM with the core first on port 0
	always @(posedge clk) begin
		if (rst) begin
			coreReadValid <= 1'b0;
			wbReadValid <= 1'b0;
		end else begin
			coreReadValid <= coreSramReq && coreReadEnable;
			wbReadValid <= wbSramReq && wbReadEnable;
			coreExpect <= refSram[coreIndex];
			wbExpect <= refSram[wbIndex]; // Old word on a same-cycle write
			if (coreSramReq) begin
				// Any core hit holds off the Wishbone write
				if (!coreReadEnable)
					refSram[coreIndex] <= mergeLanes(refSram[coreIndex], coreDataWrite,
						coreByteSelect);
			end else if (wbWriteReq) begin
				refSram[wbIndex] <= mergeLanes(refSram[wbIndex], wbDataWrite, wbByteSelect);
			end
		end
	end

	coreReadCheck: assert property (@(negedge clk) disable iff (rst)
		coreReadValid |-> coreDataRead == coreExpect)
	else begin
		errorCount++;
		$display("Error at %0t: coreDataRead %h, expected %h", $time, coreDataRead, coreExpect);
	end

	wbReadCheck: assert property (@(negedge clk) disable iff (rst)
		wbReadValid |-> wbDataRead == wbExpect)
	else begin
		errorCount++;
		$display("Error at %0t: wbDataRead %h, expected %h", $time, wbDataRead, wbExpect);
	end

	wbHoldCheck: assert property (@(negedge clk) disable iff (rst)
		wbWriteBusy == (wbWriteReq && coreSramReq))
	else begin
		errorCount++;
		$display("Error at %0t: wbWriteBusy is %b during a port 0 conflict check", $time, wbWriteBusy);
	end

	coreBusyCheck: assert property (@(negedge clk) disable iff (rst)
		!coreFlashReq |-> !coreBusy)
	else begin
		errorCount++;
		$display("Error at %0t: coreBusy high without a flash request", $time);
	end

	task automatic failRun();
		$display("Verification failed");
		$finish;
	endtask

	task automatic reportTest(input string name);
		$display("Test %s finished with %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	task automatic driveCore(input logic [addressWidth-1:0] address, input logic write,
			input logic read, input logic [3:0] lanes, input logic [dataWidth-1:0] data);
		coreAddress <= address;
		coreWriteEnable <= write;
		coreReadEnable <= read;
		coreByteSelect <= lanes;
		coreDataWrite <= data;
	endtask

	task automatic driveWb(input logic [addressWidth-1:0] address, input logic write,
			input logic read, input logic [3:0] lanes, input logic [dataWidth-1:0] data);
		wbAddress <= address;
		wbWriteEnable <= write;
		wbReadEnable <= read;
		wbByteSelect <= lanes;
		wbDataWrite <= data;
	endtask

	task automatic idleBoth();
		driveCore('0, 1'b0, 1'b0, '0, '0);
		driveWb('0, 1'b0, 1'b0, '0, '0);
	endtask

	// Strobe held until busy falls, then dropped at the next edge
	task automatic flashAccess(input logic [addressWidth-1:0] address, input logic write,
			input logic [3:0] lanes, input logic [dataWidth-1:0] data, input logic timed);
		int busyCycles;
		logic [9:0] index;
		index = address[11:2];
		busyCycles = 0;
		@(posedge clk);
		driveCore(address, write, !write, lanes, data);
		@(negedge clk);
		while (coreBusy && busyCycles <= clearCycles + flashWaitCycles + 8) begin
			busyCycles++;
			@(negedge clk);
		end
		if (coreBusy) begin
			$display("Timeout: coreBusy never fell during a flash access");
			failRun();
		end
		assert (!timed || busyCycles == flashWaitCycles + 1) else begin
			errorCount++;
			$display("Error at %0t: coreBusy high for %0d cycles, expected %0d",
				$time, busyCycles, flashWaitCycles + 1);
		end
		if (write) begin
			refFlash[index] = mergeLanes(refFlash[index], data, lanes);
		end else begin
			assert (coreDataRead == refFlash[index]) else begin
				errorCount++;
				$display("Error at %0t: flash word %0d read %h, expected %h",
					$time, index, coreDataRead, refFlash[index]);
			end
		end
		@(posedge clk);
		driveCore('0, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic coreSramTest();
		for (int i = 0; i < windowWords; i++) begin
			@(posedge clk);
			driveCore(sramAddress(i), 1'b1, 1'b0, 4'hf, $random(seed)); // Fill window
		end
		for (int i = 0; i < sramOps; i++) begin
			@(posedge clk);
			driveCore(sramAddress(randomBelow(windowWords)), 1'b1, 1'b0,
				4'($random(seed)), $random(seed));
		end
		for (int i = 0; i < sramOps; i++) begin
			@(posedge clk);
			driveCore(sramAddress(randomBelow(windowWords)), 1'b0, 1'b1, 4'hf, '0);
		end
		@(posedge clk);
		idleBoth();
		reportTest("core SRAM");
	endtask

	task automatic wbSramTest();
		int index;
		for (int i = 0; i < wbOps; i++) begin
			@(posedge clk);
			driveWb(sramAddress(randomBelow(windowWords)), 1'b1, 1'b0,
				4'($random(seed)), $random(seed));
		end
		for (int i = 0; i < wbOps; i++) begin
			@(posedge clk);
			driveWb(sramAddress(randomBelow(windowWords)), 1'b0, 1'b1, 4'hf, '0);
		end
		// Port 1 read against a port 0 write of the same word
		for (int i = 0; i < 8; i++) begin
			index = randomBelow(windowWords);
			@(posedge clk);
			driveWb(sramAddress(index), 1'b0, 1'b1, 4'hf, '0);
			driveCore(sramAddress(index), 1'b1, 1'b0, 4'hf, $random(seed));
		end
		@(posedge clk);
		idleBoth();
		reportTest("Wishbone SRAM");
	endtask

	task automatic collisionTest();
		int coreCycles;
		int index;
		int waited;
		for (int round = 0; round < collisionRounds; round++) begin
			coreCycles = 1 + randomBelow(3);
			index = randomBelow(windowWords);
			@(posedge clk);
			driveWb(sramAddress(index), 1'b1, 1'b0, 4'($random(seed)), $random(seed));
			driveCore(sramAddress(round % 2 == 1 ? index : randomBelow(windowWords)), 1'b1, 1'b0,
				4'($random(seed)), $random(seed));
			for (int i = 1; i < coreCycles; i++) begin
				@(posedge clk);
				driveCore(sramAddress(index), 1'b1, 1'b0, 4'($random(seed)), $random(seed));
			end
			@(posedge clk);
			driveCore('0, 1'b0, 1'b0, '0, '0);
			waited = 0;
			@(negedge clk);
			while (wbWriteBusy && waited < 8) begin
				waited++;
				@(negedge clk);
			end
			if (wbWriteBusy) begin
				$display("Timeout: wbWriteBusy stayed high with the core idle");
				failRun();
			end
			@(posedge clk);
			driveWb('0, 1'b0, 1'b0, '0, '0);
			driveCore(sramAddress(index), 1'b0, 1'b1, 4'hf, '0); // Held write landed last
		end
		@(posedge clk);
		idleBoth();
		reportTest("collision");
	endtask

	task automatic flashTest();
		flashAccess(flashAddressAt(0), 1'b0, 4'hf, '0, 1'b0); // Waits out the clear
		for (int i = 0; i < flashOps; i++)
			flashAccess(flashAddressAt(randomBelow(16)), 1'b1, 4'($random(seed)),
				$random(seed), 1'b1);
		for (int i = 0; i < flashOps; i++)
			flashAccess(flashAddressAt(randomBelow(16)), 1'b0, 4'hf, '0, 1'b1);
		reportTest("core flash");
	endtask

	task automatic rangeTest();
		int index;
		for (int i = 0; i < rangeOps; i++) begin
			index = randomBelow(windowWords);
			@(posedge clk);
			driveCore(sramAddress(index) | (24'(1 + randomBelow(511)) << (sramAddressSize + 2)),
				1'b1, 1'b0, 4'hf, $random(seed));
			driveWb({regionFlash, 20'(index * 4)}, 1'b1, 1'b0, 4'hf, $random(seed));
			@(posedge clk);
			driveCore({4'h2, 20'(index * 4)}, 1'b1, 1'b0, 4'hf, $random(seed)); // Unmapped
			driveWb(sramAddress(index), 1'b0, 1'b1, 4'hf, '0);
			@(posedge clk);
			driveCore(sramAddress(index), 1'b0, 1'b1, 4'hf, '0); // Aliased word unchanged
			driveWb('0, 1'b0, 1'b0, '0, '0);
		end
		@(posedge clk);
		idleBoth();
		reportTest("range");
	endtask

	task automatic mixedTest();
		int pick;
		int wbPick;
		logic hold;
		for (int i = 0; i < mixedCycles; i++) begin
			@(negedge clk);
			hold = wbWriteBusy;
			pick = randomBelow(8);
			wbPick = randomBelow(4);
			if (pick == 7) begin
				flashAccess(flashAddressAt(randomBelow(16)), 1'($random(seed)),
					4'($random(seed)), $random(seed), 1'b1);
			end else begin
				@(posedge clk);
				// 0 and 1 idle, 6 raises both enables
				driveCore(sramAddress(randomBelow(windowWords)), pick inside {2, 3, 6},
					pick inside {4, 5, 6}, 4'($random(seed)), $random(seed));
				if (!hold)
					driveWb(sramAddress(randomBelow(windowWords)), wbPick[0], wbPick[1],
						4'($random(seed)), $random(seed));
			end
		end
		@(posedge clk);
		idleBoth();
		reportTest("mixed");
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles", watchdogCycles);
		failRun();
	end

	initial begin
		rst = 1'b1;
		idleBoth();
		foreach (refFlash[i])
			refFlash[i] = '0;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!coreBusy && !wbWriteBusy) else begin
			errorCount++;
			$display("Error at %0t: busy output active after reset", $time);
		end
		coreSramTest();
		wbSramTest();
		collisionTest();
		flashTest();
		rangeTest();
		mixedTest();
		$display("6 tests run, %0d errors", errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			failRun();
		end
	end

endmodule

`default_nettype wire

// File: src/LocalMemorySubsystem.sv
`default_nettype none

module LocalMemorySubsystem #(
		parameter int sramAddressSize = 9,
		parameter int flashWaitCycles = 4
	)(
		input logic clk,
		input logic rst,

		// Core port
		input logic [memMapPkg::addressWidth-1:0] coreAddress,
		input logic [busPkg::byteSelectWidth-1:0] coreByteSelect,
		input logic coreWriteEnable,
		input logic coreReadEnable,
		input logic [busPkg::dataWidth-1:0] coreDataWrite,
		output logic [busPkg::dataWidth-1:0] coreDataRead,
		output logic coreBusy,

		// Wishbone port
		input logic [memMapPkg::addressWidth-1:0] wbAddress,
		input logic [busPkg::byteSelectWidth-1:0] wbByteSelect,
		input logic wbWriteEnable,
		input logic wbReadEnable,
		input logic [busPkg::dataWidth-1:0] wbDataWrite,
		output logic [busPkg::dataWidth-1:0] wbDataRead,
		output logic wbWriteBusy
	);

	import busPkg::*;

	// SRAM port wires
	logic csb0;
	logic web0;
	logic [byteSelectWidth-1:0] wmask0;
	logic [sramAddressSize-1:0] addr0;
	logic [dataWidth-1:0] din0;
	logic [dataWidth-1:0] dout0;
	logic csb1;
	logic [sramAddressSize-1:0] addr1;
	logic [dataWidth-1:0] dout1;

	// Flash wires
	logic [flashAddressWidth-1:0] flashAddress;
	logic [byteSelectWidth-1:0] flashByteSelect;
	logic flashWriteEnable;
	logic flashReadEnable;
	logic [dataWidth-1:0] flashDataWrite;
	logic [dataWidth-1:0] flashDataRead;
	logic flashBusy;

	LocalMemoryInterface #(
		.sramAddressSize(sramAddressSize)
	) u_LocalMemoryInterface (
		.clk, .rst,
		.coreAddress, .coreByteSelect, .coreWriteEnable, .coreReadEnable,
		.coreDataWrite, .coreDataRead, .coreBusy,
		.wbAddress, .wbByteSelect, .wbWriteEnable, .wbReadEnable,
		.wbDataWrite, .wbDataRead, .wbWriteBusy,
		.csb0, .web0, .wmask0, .addr0, .din0, .dout0,
		.csb1, .addr1, .dout1,
		.flashAddress, .flashByteSelect, .flashWriteEnable, .flashReadEnable,
		.flashDataWrite, .flashDataRead, .flashBusy
	);

	SramMacro #(
		.sramAddressSize(sramAddressSize)
	) u_SramMacro (
		.clk,
		.csb0, .web0, .wmask0, .addr0, .din0, .dout0,
		.csb1, .addr1, .dout1
	);

	FlashController #(
		.flashWaitCycles(flashWaitCycles)
	) u_FlashController (
		.clk, .rst,
		.flashAddress, .flashByteSelect, .flashWriteEnable, .flashReadEnable,
		.flashDataWrite, .flashDataRead, .flashBusy
	);

endmodule

`default_nettype wire

// File: src/LocalMemoryInterface.sv
`default_nettype none

module LocalMemoryInterface #(
		parameter int sramAddressSize = 9
	)(
		input logic clk,
		input logic rst,

		// Core port
		input logic [memMapPkg::addressWidth-1:0] coreAddress,
		input logic [busPkg::byteSelectWidth-1:0] coreByteSelect,
		input logic coreWriteEnable,
		input logic coreReadEnable,
		input logic [busPkg::dataWidth-1:0] coreDataWrite,
		output logic [busPkg::dataWidth-1:0] coreDataRead,
		output logic coreBusy,

		// Wishbone port
		input logic [memMapPkg::addressWidth-1:0] wbAddress,
		input logic [busPkg::byteSelectWidth-1:0] wbByteSelect,
		input logic wbWriteEnable,
		input logic wbReadEnable,
		input logic [busPkg::dataWidth-1:0] wbDataWrite,
		output logic [busPkg::dataWidth-1:0] wbDataRead,
		output logic wbWriteBusy,

		// SRAM read/write port
		output logic csb0,
		output logic web0,
		output logic [busPkg::byteSelectWidth-1:0] wmask0,
		output logic [sramAddressSize-1:0] addr0,
		output logic [busPkg::dataWidth-1:0] din0,
		input logic [busPkg::dataWidth-1:0] dout0,

		// SRAM read port
		output logic csb1,
		output logic [sramAddressSize-1:0] addr1,
		input logic [busPkg::dataWidth-1:0] dout1,

		// Flash controller
		output logic [busPkg::flashAddressWidth-1:0] flashAddress,
		output logic [busPkg::byteSelectWidth-1:0] flashByteSelect,
		output logic flashWriteEnable,
		output logic flashReadEnable,
		output logic [busPkg::dataWidth-1:0] flashDataWrite,
		input logic [busPkg::dataWidth-1:0] flashDataRead,
		input logic flashBusy
	);

	import memMapPkg::*;
	import busPkg::*;

	localparam int flashWordBits = offsetWidth - byteOffsetWidth;

	LocalAddress coreAddr;
	LocalAddress wbAddr;
	logic coreFromFlash; // Last core cycle was a flash wait cycle

	assign coreAddr = coreAddress;
	assign wbAddr = wbAddress;

	wire coreAccess = coreWriteEnable || coreReadEnable;
	wire wbAccess = wbWriteEnable || wbReadEnable;

	// Region match plus no offset bits above the SRAM words
	wire coreSramHit = coreAddr.mapView.region == regionSram && coreAccess
		&& (coreAddr.mapView.offset >> (sramAddressSize + byteOffsetWidth)) == '0;
	wire wbSramHit = wbAddr.mapView.region == regionSram && wbAccess
		&& (wbAddr.mapView.offset >> (sramAddressSize + byteOffsetWidth)) == '0;
	wire coreFlashHit = coreAddr.mapView.region == regionFlash && coreAccess;

	// Both enables high counts as a read
	wire coreSramWrite = coreSramHit && !coreReadEnable;
	wire wbSramWrite = wbSramHit && !wbReadEnable;
	wire wbSramRead = wbSramHit && wbReadEnable;
	wire wbOwnsPort0 = wbSramWrite && !coreSramHit; // Core first on port 0

	assign csb0 = !(coreSramHit || wbOwnsPort0);
	assign web0 = !(coreSramWrite || wbOwnsPort0);
	assign wmask0 = coreSramHit ? coreByteSelect :
					wbOwnsPort0 ? wbByteSelect :
					'0;
	assign addr0 = coreSramHit ? coreAddr.wordView.wordAddress[sramAddressSize-1:0] :
				   wbAddr.wordView.wordAddress[sramAddressSize-1:0];
	assign din0 = coreSramHit ? coreDataWrite : wbDataWrite;

	assign csb1 = !wbSramRead;
	assign addr1 = wbAddr.wordView.wordAddress[sramAddressSize-1:0];
	assign wbDataRead = dout1;
	assign wbWriteBusy = wbSramWrite && coreSramHit;

	// Flash sees the word part of the region offset
	assign flashAddress = {{(flashAddressWidth - offsetWidth){1'b0}},
		coreAddr.wordView.wordAddress[flashWordBits-1:0], {byteOffsetWidth{1'b0}}};
	assign flashByteSelect = coreByteSelect;
	assign flashDataWrite = coreDataWrite;
	assign flashReadEnable = coreFlashHit && coreReadEnable;
	assign flashWriteEnable = coreFlashHit && coreWriteEnable && !coreReadEnable;

	always_ff @(posedge clk) begin
		if (rst)
			coreFromFlash <= 1'b0;
		else
			coreFromFlash <= coreFlashHit && flashBusy;
	end

	// Busy from the request cycle until the done cycle
	assign coreBusy = coreFlashHit && (flashBusy || !coreFromFlash);
	assign coreDataRead = coreFromFlash ? flashDataRead : dout0;

endmodule

`default_nettype wire

// File: src/FlashController.sv
`default_nettype none

module FlashController #(
		parameter int flashWaitCycles = 4
	)(
		input logic clk,
		input logic rst,

		input logic [busPkg::flashAddressWidth-1:0] flashAddress,
		input logic [busPkg::byteSelectWidth-1:0] flashByteSelect,
		input logic flashWriteEnable,
		input logic flashReadEnable,
		input logic [busPkg::dataWidth-1:0] flashDataWrite,
		output logic [busPkg::dataWidth-1:0] flashDataRead,
		output logic flashBusy
	);

	import busPkg::*;

	localparam int flashIndexWidth = 10; // 1024 words
	localparam int laneBits = $clog2(byteSelectWidth);
	localparam int waitCountWidth = $clog2(flashWaitCycles + 1);
	localparam logic [waitCountWidth-1:0] waitStart = waitCountWidth'(flashWaitCycles - 1);

	typedef enum logic [1:0] {
		stateClear,
		stateIdle,
		stateWait,
		stateDone
	} FlashState;

	FlashState state;
	FlashState nextState;
	logic [waitCountWidth-1:0] waitCount;
	logic [flashIndexWidth-1:0] clearIndex;
	logic [dataWidth-1:0] flashArray [2 ** flashIndexWidth];

	wire [flashIndexWidth-1:0] wordIndex = flashAddress[laneBits +: flashIndexWidth];
	wire accessRequest = flashReadEnable || flashWriteEnable;
	wire clearDone = clearIndex == '1;
	wire lastWait = state == stateWait && waitCount == '0; // Access completes at this edge

	always_comb begin
		nextState = state;
		case (state)
			stateClear: if (clearDone) nextState = accessRequest ? stateWait : stateIdle;
			stateIdle: if (accessRequest) nextState = stateWait;
			stateWait: if (waitCount == '0) nextState = stateDone;
			stateDone: nextState = stateIdle;
			default: nextState = stateIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateClear;
			clearIndex <= '0;
			waitCount <= '0;
			flashBusy <= 1'b0;
		end else begin
			state <= nextState;
			flashBusy <= nextState == stateWait || nextState == stateClear;
			if (state == stateClear)
				clearIndex <= clearIndex + 1'b1;
			// Load on entry, count down while waiting
			if (state != stateWait && nextState == stateWait)
				waitCount <= waitStart;
			else if (state == stateWait && waitCount != '0)
				waitCount <= waitCount - 1'b1;
		end
	end

	// Zero fill after reset, then masked writes
	always_ff @(posedge clk) begin
		if (state == stateClear) begin
			flashArray[clearIndex] <= '0;
		end else if (lastWait && flashWriteEnable && !flashReadEnable) begin
			for (int lane = 0; lane < byteSelectWidth; lane++) begin
				if (flashByteSelect[lane])
					flashArray[wordIndex][lane*byteWidth +: byteWidth] <= flashDataWrite[lane*byteWidth +: byteWidth];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lastWait && flashReadEnable)
			flashDataRead <= flashArray[wordIndex]; // Valid in the done cycle
	end

endmodule

`default_nettype wire

// File: src/SramMacro.sv
`default_nettype none

module SramMacro #(
		parameter int sramAddressSize = 9
	)(
		input logic clk,

		// Read/write port
		input logic csb0, // Active low select
		input logic web0, // Active low write
		input logic [busPkg::byteSelectWidth-1:0] wmask0,
		input logic [sramAddressSize-1:0] addr0,
		input logic [busPkg::dataWidth-1:0] din0,
		output logic [busPkg::dataWidth-1:0] dout0,

		// Read-only port
		input logic csb1,
		input logic [sramAddressSize-1:0] addr1,
		output logic [busPkg::dataWidth-1:0] dout1
	);

	import busPkg::*;

	localparam int sramWords = 2 ** sramAddressSize;

	logic [dataWidth-1:0] sramArray [sramWords];

	// Port 0 writes masked lanes or reads into dout0
	always_ff @(posedge clk) begin
		if (!csb0) begin
			if (!web0) begin
				for (int lane = 0; lane < byteSelectWidth; lane++) begin
					if (wmask0[lane])
						sramArray[addr0][lane*byteWidth +: byteWidth] <= din0[lane*byteWidth +: byteWidth];
				end
			end else begin
				dout0 <= sramArray[addr0];
			end
		end
	end

	// Old word on a same-cycle write from port 0
	always_ff @(posedge clk) begin
		if (!csb1)
			dout1 <= sramArray[addr1];
	end

endmodule

`default_nettype wire

// File: src/busPkg.sv
`default_nettype none

package busPkg;

	localparam int dataWidth = 32;
	localparam int byteSelectWidth = 4; // One bit per lane
	localparam int byteWidth = dataWidth / byteSelectWidth;

	// Byte address seen by the flash controller
	localparam int flashAddressWidth = 28;

endpackage

`default_nettype wire

// File: src/memMapPkg.sv
`default_nettype none

package memMapPkg;

	localparam int addressWidth = 24;
	localparam int regionWidth = 4;
	localparam int offsetWidth = addressWidth - regionWidth;
	localparam int byteOffsetWidth = 2;
	localparam int wordAddressWidth = addressWidth - byteOffsetWidth;

	// Region codes in the top address nibble
	localparam logic [regionWidth-1:0] regionSram = 4'd0;
	localparam logic [regionWidth-1:0] regionFlash = 4'd1;

	// Region select and offset within the region
	typedef struct packed {
		logic [regionWidth-1:0] region;
		logic [offsetWidth-1:0] offset;
	} MapView;

	// Word index and byte lane
	typedef struct packed {
		logic [wordAddressWidth-1:0] wordAddress;
		logic [byteOffsetWidth-1:0] byteOffset;
	} WordView;

	// Same 24-bit address, read either by region or by word
	typedef union packed {
		MapView mapView;
		WordView wordView;
	} LocalAddress;

endpackage

`default_nettype wire
